// File: tlu_pkg.sv
// shared constants and types for the TLU controller; FIFO depth must stay a power of two
package tlu_pkg;

    // input channels, in generate-loop order
    localparam int num_inputs      = 4;
    localparam int ch_rj45_trigger = 0;
    localparam int ch_lemo_trigger = 1;
    localparam int ch_rj45_reset   = 2;
    localparam int ch_lemo_reset   = 3;

    // bus and data widths
    localparam int abus_width     = 16;
    localparam int data_width     = 8;
    localparam int word_width     = 32;
    localparam int fifo_depth     = 8;
    localparam int fifo_ptr_width = $clog2(fifo_depth);

    localparam logic [data_width-1:0] version = 8'd1;

    // register map
    localparam logic [abus_width-1:0] addr_ctrl        = 16'd0;
    localparam logic [abus_width-1:0] addr_mode        = 16'd1;
    localparam logic [abus_width-1:0] addr_invert      = 16'd2;
    localparam logic [abus_width-1:0] addr_low_timeout = 16'd3;
    localparam logic [abus_width-1:0] addr_lost        = 16'd4;
    // four bytes of trigger number, lsb first
    localparam logic [abus_width-1:0] addr_trig_num    = 16'd8;

    typedef enum logic [1:0]
    {
        mode_disabled         = 2'd0,
        mode_no_handshake     = 2'd1,
        mode_simple_handshake = 2'd2,
        mode_reserved         = 2'd3
    } tlu_mode_e;

    typedef enum logic
    {
        st_idle,
        st_wait_low
    } handler_state_e;

endpackage

// File: tlu_input_channel.sv
// one trigger or reset input; pin is asynchronous, level lags it by three BUS_CLK edges
`timescale 1ns/1ns

module tlu_input_channel
(
    input  logic BUS_CLK,
    input  logic core_rst,
    input  logic pin,
    input  logic invert,
    output logic level,
    output logic rise
);

    logic [2:0] sync_ff;
    logic       level_d;

    // polarity applied ahead of the first flop
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            sync_ff <= '0;
            level_d <= 1'b0;
        end
        else
        begin
            sync_ff <= {sync_ff[1:0], pin ^ invert};
            level_d <= sync_ff[2];
        end
    end

    assign level = sync_ff[2];
    assign rise  = sync_ff[2] & ~level_d;

endmodule

// File: tlu_reg_bank.sv
// 8-bit register bus, read data registered one edge after the address; no bus wait states
`timescale 1ns/1ns

module tlu_reg_bank import tlu_pkg::*;
(
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic [abus_width-1:0] BUS_ADD,
    input  logic [data_width-1:0] BUS_DATA_IN,
    input  logic                  BUS_WR,
    input  logic                  BUS_RD,
    output logic [data_width-1:0] BUS_DATA_OUT,
    output logic                  core_rst,
    output logic [num_inputs-1:0] invert_mask,
    output tlu_mode_e             mode,
    output logic                  enable_reset,
    output logic [data_width-1:0] low_timeout,
    output logic                  set_num_strobe,
    output logic [word_width-1:0] set_num_value,
    input  logic [word_width-1:0] trig_num,
    input  logic [data_width-1:0] lost_cnt
);

    logic                  soft_rst;
    logic [data_width-1:0] mode_reg;
    logic [data_width-1:0] invert_reg;
    logic [data_width-1:0] timeout_reg;
    logic [data_width-1:0] set_bytes [4];
    logic [word_width-1:8] trig_buf;
    logic                  wr_trig_num;

    assign wr_trig_num = BUS_WR && (BUS_ADD[abus_width-1:2] == addr_trig_num[abus_width-1:2]);

    // soft reset pulse follows a write to address 0
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            soft_rst       <= 1'b0;
            set_num_strobe <= 1'b0;
        end
        else
        begin
            soft_rst       <= BUS_WR && (BUS_ADD == addr_ctrl);
            set_num_strobe <= BUS_WR && (BUS_ADD == addr_trig_num + 16'd3);
        end
    end

    assign core_rst = RST | soft_rst;

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            mode_reg    <= '0;
            invert_reg  <= '0;
            timeout_reg <= '0;
        end
        else if (BUS_WR)
        begin
            if (BUS_ADD == addr_mode)
                mode_reg <= BUS_DATA_IN;
            if (BUS_ADD == addr_invert)
                invert_reg <= BUS_DATA_IN;
            if (BUS_ADD == addr_low_timeout)
                timeout_reg <= BUS_DATA_IN;
        end
    end

    // staging bytes for loading the trigger number
    always_ff @(posedge BUS_CLK)
    begin
        if (wr_trig_num)
            set_bytes[BUS_ADD[1:0]] <= BUS_DATA_IN;
    end

    // upper bytes frozen when the low byte is read
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            trig_buf <= '0;
        else if (BUS_RD && (BUS_ADD == addr_trig_num))
            trig_buf <= trig_num[word_width-1:8];
    end

    always_ff @(posedge BUS_CLK)
    begin
        case (BUS_ADD)
            addr_ctrl:              BUS_DATA_OUT <= version;
            addr_mode:              BUS_DATA_OUT <= mode_reg;
            addr_invert:            BUS_DATA_OUT <= invert_reg;
            addr_low_timeout:       BUS_DATA_OUT <= timeout_reg;
            addr_lost:              BUS_DATA_OUT <= lost_cnt;
            addr_trig_num:          BUS_DATA_OUT <= trig_num[7:0];
            addr_trig_num + 16'd1:  BUS_DATA_OUT <= trig_buf[15:8];
            addr_trig_num + 16'd2:  BUS_DATA_OUT <= trig_buf[23:16];
            addr_trig_num + 16'd3:  BUS_DATA_OUT <= trig_buf[31:24];
            default:                BUS_DATA_OUT <= '0;
        endcase
    end

    assign mode          = tlu_mode_e'(mode_reg[1:0]);
    assign enable_reset  = mode_reg[2];
    assign invert_mask   = invert_reg[num_inputs-1:0];
    assign low_timeout   = timeout_reg;
    assign set_num_value = {set_bytes[3], set_bytes[2], set_bytes[1], set_bytes[0]};

endmodule

// File: tlu_port_select.sv
// unplugged RJ45 reads high on both lines; that keeps LEMO selected until RJ45 goes low once
`timescale 1ns/1ns

module tlu_port_select import tlu_pkg::*;
(
    input  logic                  BUS_CLK,
    input  logic                  core_rst,
    input  logic [num_inputs-1:0] chan_level,
    input  logic [num_inputs-1:0] chan_rise,
    input  tlu_mode_e             mode,
    input  logic                  enable_reset,
    output logic                  rj45_enabled,
    output logic                  trig_level,
    output logic                  trig_rise,
    output logic                  tlu_reset_flag
);

    logic rj45_idle_high;
    logic mode_off;

    assign rj45_idle_high = chan_level[ch_rj45_trigger] & chan_level[ch_rj45_reset];
    assign mode_off       = (mode == mode_disabled) || (mode == mode_reserved);

    // once enabled, RJ45 stays on until the mode turns off
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            rj45_enabled <= 1'b0;
        else if (mode_off || (rj45_idle_high && !rj45_enabled))
            rj45_enabled <= 1'b0;
        else
            rj45_enabled <= 1'b1;
    end

    assign trig_level = rj45_enabled ? chan_level[ch_rj45_trigger] : chan_level[ch_lemo_trigger];
    assign trig_rise  = rj45_enabled ? chan_rise[ch_rj45_trigger] : chan_rise[ch_lemo_trigger];
    assign tlu_reset_flag = enable_reset &
        (rj45_enabled ? chan_rise[ch_rj45_reset] : chan_rise[ch_lemo_reset]);

endmodule

// File: tlu_trigger_handler.sv
// trigger number wraps at 2^32 but only bits 30:0 reach the FIFO word; timestamp wraps freely
`timescale 1ns/1ns

module tlu_trigger_handler import tlu_pkg::*;
(
    input  logic                  BUS_CLK,
    input  logic                  core_rst,
    input  tlu_mode_e             mode,
    input  logic [data_width-1:0] low_timeout,
    input  logic                  trig_level,
    input  logic                  trig_rise,
    input  logic                  tlu_reset_flag,
    input  logic                  set_num_strobe,
    input  logic [word_width-1:0] set_num_value,
    output logic                  tlu_busy,
    output logic                  wr_strobe,
    output logic [word_width-1:0] wr_word,
    output logic [word_width-1:0] trig_num,
    output logic [word_width-1:0] timestamp
);

    handler_state_e        state;
    logic [data_width-1:0] wait_cnt;
    logic                  accept;
    logic                  timeout_hit;

    assign accept = (state == st_idle) && trig_rise &&
                    ((mode == mode_no_handshake) || (mode == mode_simple_handshake));
    assign timeout_hit = (low_timeout != '0) && (wait_cnt == low_timeout - 8'd1);

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            state     <= st_idle;
            wait_cnt  <= '0;
            wr_strobe <= 1'b0;
        end
        else
        begin
            wr_strobe <= accept;
            case (state)
                st_idle:
                begin
                    wait_cnt <= '0;
                    if (accept && (mode == mode_simple_handshake))
                        state <= st_wait_low;
                end
                st_wait_low:
                begin
                    wait_cnt <= wait_cnt + 8'd1;
                    // release on trigger low, timeout or a mode change
                    if (!trig_level || timeout_hit || (mode != mode_simple_handshake))
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // word carries the number before the increment
    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            wr_word <= {1'b1, trig_num[word_width-2:0]};
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst || tlu_reset_flag)
            trig_num <= '0;
        else if (set_num_strobe)
            trig_num <= set_num_value;
        else if (accept)
            trig_num <= trig_num + 32'd1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst || tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 32'd1;
    end

    assign tlu_busy = (state == st_wait_low);

endmodule

// File: tlu_data_fifo.sv
// writes into a full FIFO are dropped even when a pop happens in the same cycle
`timescale 1ns/1ns

module tlu_data_fifo import tlu_pkg::*;
(
    input  logic                  BUS_CLK,
    input  logic                  core_rst,
    input  logic                  wr_strobe,
    input  logic [word_width-1:0] wr_word,
    input  logic                  fifo_read,
    output logic                  fifo_empty,
    output logic [word_width-1:0] fifo_data,
    output logic [data_width-1:0] lost_cnt
);

    logic [word_width-1:0]   mem [fifo_depth];
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_ptr_width:0]   count;
    logic                      fifo_full;
    logic                      push;
    logic                      pop;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == (fifo_ptr_width + 1)'(fifo_depth));
    assign push       = wr_strobe && !fifo_full;
    assign pop        = fifo_read && !fifo_empty;

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= wr_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            lost_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            // saturates at 255
            if (wr_strobe && fifo_full && (lost_cnt != '1))
                lost_cnt <= lost_cnt + 8'd1;
        end
    end

    // head word falls through
    assign fifo_data = mem[rd_ptr];

endmodule

// File: tlu_controller_top.sv
// single clock domain; trigger and reset pins are synchronized inside, bus signals are not
`timescale 1ns/1ns

module tlu_controller_top import tlu_pkg::*;
(
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic [abus_width-1:0] BUS_ADD,
    input  logic [data_width-1:0] BUS_DATA_IN,
    input  logic                  BUS_RD,
    input  logic                  BUS_WR,
    output logic [data_width-1:0] BUS_DATA_OUT,
    input  logic                  RJ45_TRIGGER,
    input  logic                  LEMO_TRIGGER,
    input  logic                  RJ45_RESET,
    input  logic                  LEMO_RESET,
    output logic                  RJ45_ENABLED,
    output logic                  TLU_BUSY,
    input  logic                  FIFO_READ,
    output logic                  FIFO_EMPTY,
    output logic [word_width-1:0] FIFO_DATA,
    output logic [word_width-1:0] TIMESTAMP
);

    logic                  core_rst;
    logic [num_inputs-1:0] invert_mask;
    tlu_mode_e             mode;
    logic                  enable_reset;
    logic [data_width-1:0] low_timeout;
    logic                  set_num_strobe;
    logic [word_width-1:0] set_num_value;
    logic [word_width-1:0] trig_num;
    logic [data_width-1:0] lost_cnt;
    logic [num_inputs-1:0] pins;
    logic [num_inputs-1:0] chan_level;
    logic [num_inputs-1:0] chan_rise;
    logic                  trig_level;
    logic                  trig_rise;
    logic                  tlu_reset_flag;
    logic                  wr_strobe;
    logic [word_width-1:0] wr_word;

    assign pins[ch_rj45_trigger] = RJ45_TRIGGER;
    assign pins[ch_lemo_trigger] = LEMO_TRIGGER;
    assign pins[ch_rj45_reset]   = RJ45_RESET;
    assign pins[ch_lemo_reset]   = LEMO_RESET;

    tlu_reg_bank u_reg_bank
    (
        .BUS_CLK(BUS_CLK), .RST(RST), .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_WR(BUS_WR), .BUS_RD(BUS_RD), .BUS_DATA_OUT(BUS_DATA_OUT),
        .core_rst(core_rst), .invert_mask(invert_mask), .mode(mode),
        .enable_reset(enable_reset), .low_timeout(low_timeout),
        .set_num_strobe(set_num_strobe), .set_num_value(set_num_value),
        .trig_num(trig_num), .lost_cnt(lost_cnt)
    );

    for (genvar i = 0; i < num_inputs; i++)
    begin : g_chan
        tlu_input_channel u_chan
        (
            .BUS_CLK(BUS_CLK), .core_rst(core_rst), .pin(pins[i]),
            .invert(invert_mask[i]), .level(chan_level[i]), .rise(chan_rise[i])
        );
    end

    tlu_port_select u_port_select
    (
        .BUS_CLK(BUS_CLK), .core_rst(core_rst), .chan_level(chan_level),
        .chan_rise(chan_rise), .mode(mode), .enable_reset(enable_reset),
        .rj45_enabled(RJ45_ENABLED), .trig_level(trig_level), .trig_rise(trig_rise),
        .tlu_reset_flag(tlu_reset_flag)
    );

    tlu_trigger_handler u_handler
    (
        .BUS_CLK(BUS_CLK), .core_rst(core_rst), .mode(mode), .low_timeout(low_timeout),
        .trig_level(trig_level), .trig_rise(trig_rise), .tlu_reset_flag(tlu_reset_flag),
        .set_num_strobe(set_num_strobe), .set_num_value(set_num_value),
        .tlu_busy(TLU_BUSY), .wr_strobe(wr_strobe), .wr_word(wr_word),
        .trig_num(trig_num), .timestamp(TIMESTAMP)
    );

    tlu_data_fifo u_fifo
    (
        .BUS_CLK(BUS_CLK), .core_rst(core_rst), .wr_strobe(wr_strobe), .wr_word(wr_word),
        .fifo_read(FIFO_READ), .fifo_empty(FIFO_EMPTY), .fifo_data(FIFO_DATA),
        .lost_cnt(lost_cnt)
    );

endmodule

// File: tlu_checker.sv
// bound into tlu_controller_top; mode is the internal decoded mode of the register bank
`timescale 1ns/1ns

module tlu_checker import tlu_pkg::*;
(
    input logic      BUS_CLK,
    input logic      RST,
    input tlu_mode_e mode,
    input logic      TLU_BUSY,
    input logic      RJ45_ENABLED,
    input logic      FIFO_EMPTY
);

    a_empty_after_reset: assert property (@(posedge BUS_CLK) RST |=> FIFO_EMPTY)
        else $error("FIFO_EMPTY not high one cycle after reset");

    // busy only starts from an accepted trigger in simple handshake
    a_busy_only_handshake: assert property (@(posedge BUS_CLK) disable iff (RST)
        $rose(TLU_BUSY) |-> ($past(mode) == mode_simple_handshake))
        else $error("TLU_BUSY rose outside simple handshake mode");

    a_rj45_off_when_disabled: assert property (@(posedge BUS_CLK) disable iff (RST)
        (mode == mode_disabled) |=> !RJ45_ENABLED)
        else $error("RJ45_ENABLED high while mode is disabled");

endmodule

// File: tlu_monitor.sv
// samples on the falling edge half a cycle after each testbench request; TIMESTAMP every cycle
`timescale 1ns/1ns

module tlu_monitor import tlu_pkg::*;
(
    input  logic                  BUS_CLK,
    input  logic                  rst,
    input  logic [2:0]            chk_kind,
    input  logic [word_width-1:0] chk_exp,
    input  logic [data_width-1:0] bus_data_out,
    input  logic                  fifo_empty,
    input  logic [word_width-1:0] fifo_data,
    input  logic                  tlu_busy,
    input  logic                  rj45_enabled,
    input  logic [word_width-1:0] timestamp,
    output int                    error_count,
    output int                    check_count
);

    int errors = 0;
    int checks = 0;

    logic [word_width-1:0] ts_prev;
    logic [word_width-1:0] ts_exp;
    logic                  rst_prev;
    logic                  ts_valid = 1'b0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(negedge BUS_CLK)
    begin
        case (chk_kind)
            3'd1: compare_value("BUS_DATA_OUT", {24'd0, bus_data_out}, chk_exp);
            3'd2:
            begin
                // a pop needs a word at the head
                if (fifo_empty)
                begin
                    checks++;
                    errors++;
                    $display("FIFO was empty at %0t ns although a word was expected", $time);
                end
                else
                    compare_value("FIFO_DATA", fifo_data, chk_exp);
            end
            3'd3: compare_value("FIFO_EMPTY", {31'd0, fifo_empty}, chk_exp);
            3'd4: compare_value("TLU_BUSY", {31'd0, tlu_busy}, chk_exp);
            3'd5: compare_value("RJ45_ENABLED", {31'd0, rj45_enabled}, chk_exp);
            default: ;
        endcase
    end

    // timestamp counts every cycle and restarts from zero on any reset
    always @(negedge BUS_CLK)
    begin
        if (rst_prev || ((timestamp == '0) && (ts_prev != '0)))
            ts_exp = '0;
        else
            ts_exp = ts_prev + 32'd1;
        if (ts_valid)
            compare_value("TIMESTAMP", timestamp, ts_exp);
        ts_prev  = timestamp;
        rst_prev = rst;
        ts_valid = !$isunknown({timestamp, rst});
    end

endmodule

// File: tb_tlu.sv
// runs tlu_stim.txt from the project root; five hex columns per command, opcode 0 ends the list
`timescale 1ns/1ns

module tb_tlu import tlu_pkg::*;
;

    localparam int stim_words = 1024;

    logic                  BUS_CLK;
    logic                  RST;
    logic [abus_width-1:0] BUS_ADD;
    logic [data_width-1:0] BUS_DATA_IN;
    logic                  BUS_RD;
    logic                  BUS_WR;
    logic [data_width-1:0] BUS_DATA_OUT;
    logic                  rj45_trigger;
    logic                  lemo_trigger;
    logic                  rj45_reset;
    logic                  lemo_reset;
    logic                  rj45_enabled;
    logic                  tlu_busy;
    logic                  fifo_read;
    logic                  fifo_empty;
    logic [word_width-1:0] fifo_data;
    logic [word_width-1:0] timestamp;

    // monitor request kind and its expected value
    logic [2:0]            chk_kind;
    logic [word_width-1:0] chk_exp;
    int                    error_count;
    int                    check_count;

    logic [31:0] stim_mem [stim_words];
    integer      seed;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    tlu_controller_top u_dut
    (
        .BUS_CLK(BUS_CLK), .RST(RST), .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_RD(BUS_RD), .BUS_WR(BUS_WR), .BUS_DATA_OUT(BUS_DATA_OUT),
        .RJ45_TRIGGER(rj45_trigger), .LEMO_TRIGGER(lemo_trigger),
        .RJ45_RESET(rj45_reset), .LEMO_RESET(lemo_reset),
        .RJ45_ENABLED(rj45_enabled), .TLU_BUSY(tlu_busy),
        .FIFO_READ(fifo_read), .FIFO_EMPTY(fifo_empty), .FIFO_DATA(fifo_data),
        .TIMESTAMP(timestamp)
    );

    tlu_monitor u_monitor
    (
        .BUS_CLK(BUS_CLK), .rst(RST), .chk_kind(chk_kind), .chk_exp(chk_exp),
        .bus_data_out(BUS_DATA_OUT), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .tlu_busy(tlu_busy), .rj45_enabled(rj45_enabled), .timestamp(timestamp),
        .error_count(error_count), .check_count(check_count)
    );

    bind tlu_controller_top tlu_checker u_checker
    (
        .BUS_CLK(BUS_CLK), .RST(RST), .mode(mode), .TLU_BUSY(TLU_BUSY),
        .RJ45_ENABLED(RJ45_ENABLED), .FIFO_EMPTY(FIFO_EMPTY)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #4 BUS_CLK = ~BUS_CLK;
    end

    always @(posedge BUS_CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit))
        begin
            $display("Timeout: stimulus did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic bit is_command(input logic [31:0] v);
        return !$isunknown(v) && (v >= 32'd1) && (v <= 32'd9);
    endfunction

    // rough cycle cost of one command for the timeout
    function automatic int cost(input logic [31:0] op, a, b, c, d);
        case (op)
            32'd1: return 2;
            32'd2: return 3;
            32'd3: return int'(d) * (int'(c) + 4) + 1;
            32'd4: return 1;
            32'd5: return 2 * int'(b);
            32'd9: return int'(a) + 3;
            default: return 2;
        endcase
    endfunction

    task automatic drive_pin(input logic [31:0] idx, input logic val);
        case (idx)
            32'd0: rj45_trigger <= val;
            32'd1: lemo_trigger <= val;
            32'd2: rj45_reset <= val;
            default: lemo_reset <= val;
        endcase
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= addr;
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [31:0] exp);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_RD  <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD   <= 1'b0;
        chk_kind <= 3'd1;
        chk_exp  <= exp;
        @(posedge BUS_CLK);
        chk_kind <= 3'd0;
    endtask

    task automatic expect_level(input logic [2:0] kind, input logic [31:0] exp);
        @(posedge BUS_CLK);
        chk_kind <= kind;
        chk_exp  <= exp;
        @(posedge BUS_CLK);
        chk_kind <= 3'd0;
    endtask

    task automatic pulse_pin(input logic [31:0] idx, input logic lvl, input int width,
                             input int reps);
        for (int r = 0; r < reps; r++)
        begin
            @(posedge BUS_CLK);
            drive_pin(idx, lvl);
            repeat (width - 1) @(posedge BUS_CLK);
            @(posedge BUS_CLK);
            drive_pin(idx, !lvl);
            repeat (3) @(posedge BUS_CLK);
        end
    endtask

    // words are numbered consecutively from the first one
    task automatic pop_words(input logic [31:0] first, input int count);
        for (int i = 0; i < count; i++)
        begin
            @(posedge BUS_CLK);
            chk_kind  <= 3'd2;
            chk_exp   <= first + 32'(i);
            fifo_read <= 1'b1;
            @(posedge BUS_CLK);
            chk_kind  <= 3'd0;
            fifo_read <= 1'b0;
        end
    endtask

    task automatic idle(input int cycles);
        int gap;
        gap = $random(seed) & 3;
        repeat (cycles + gap) @(posedge BUS_CLK);
    endtask

    task automatic run_command(input logic [31:0] op, a, b, c, d);
        case (op)
            32'd1: bus_write(a[15:0], b[7:0]);
            32'd2: bus_read(a[15:0], b);
            32'd3: pulse_pin(a, b[0], int'(c), int'(d));
            32'd4:
            begin
                @(posedge BUS_CLK);
                drive_pin(a, b[0]);
            end
            32'd5: pop_words(a, int'(b));
            32'd6: expect_level(3'd3, a);
            32'd7: expect_level(3'd4, a);
            32'd8: expect_level(3'd5, a);
            default: idle(int'(a));
        endcase
    endtask

    initial
    begin
        int idx;
        int total;
        seed         = 32'h4b15;
        RST          = 1'b1;
        BUS_ADD      = '0;
        BUS_DATA_IN  = '0;
        BUS_RD       = 1'b0;
        BUS_WR       = 1'b0;
        // unplugged RJ45 idles high
        rj45_trigger = 1'b1;
        rj45_reset   = 1'b1;
        lemo_trigger = 1'b0;
        lemo_reset   = 1'b0;
        fifo_read    = 1'b0;
        chk_kind     = 3'd0;
        chk_exp      = '0;
        $readmemh("tlu_stim.txt", stim_mem);
        total = 5;
        idx = 0;
        while ((idx + 4 < stim_words) && is_command(stim_mem[idx]))
        begin
            total += cost(stim_mem[idx], stim_mem[idx+1], stim_mem[idx+2],
                          stim_mem[idx+3], stim_mem[idx+4]);
            idx += 5;
        end
        cycle_limit = 2 * total + 500;
        repeat (5) @(posedge BUS_CLK);
        RST <= 1'b0;
        idx = 0;
        while ((idx + 4 < stim_words) && is_command(stim_mem[idx]))
        begin
            run_command(stim_mem[idx], stim_mem[idx+1], stim_mem[idx+2],
                        stim_mem[idx+3], stim_mem[idx+4]);
            idx += 5;
        end
        repeat (2) @(posedge BUS_CLK);
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if ((error_count == 0) && (check_count > 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tlu_stim.txt
// columns: opcode arg_a arg_b arg_c arg_d, all hex
// 1 wr addr data | 2 rd addr exp | 3 pulse pin lvl width reps | 4 hold pin lvl
// 5 pop first_word count | 6 empty exp | 7 busy exp | 8 rj45 exp | 9 idle cycles | 0 end
// pins: 0 rj45 trigger, 1 lemo trigger, 2 rj45 reset, 3 lemo reset
2 0000 01 0 0
1 0001 04 0 0
1 0002 50 0 0
1 0003 7c 0 0
2 0001 04 0 0
2 0002 50 0 0
2 0003 7c 0 0
1 0000 00 0 0
2 0001 00 0 0
2 0002 00 0 0
2 0003 00 0 0
6 1 0 0 0
8 0 0 0 0
// no handshake on LEMO, numbers start from a loaded value
1 0008 30 0 0
1 0009 12 0 0
1 000a 00 0 0
1 000b 01 0 0
2 0008 30 0 0
2 0009 12 0 0
2 000a 00 0 0
2 000b 01 0 0
1 0001 01 0 0
3 1 1 2 3
7 0 0 0 0
8 0 0 0 0
9 8 0 0 0
5 81001230 3 0 0
6 1 0 0 0
// simple handshake, release by level then by timeout
1 0001 02 0 0
4 1 1 0 0
9 6 0 0 0
7 1 0 0 0
4 1 0 0 0
9 6 0 0 0
7 0 0 0 0
4 1 1 0 0
9 6 0 0 0
7 1 0 0 0
4 1 0 0 0
9 6 0 0 0
7 0 0 0 0
5 81001233 2 0 0
6 1 0 0 0
1 0003 05 0 0
4 1 1 0 0
9 e 0 0 0
7 0 0 0 0
4 1 0 0 0
9 6 0 0 0
5 81001235 1 0 0
6 1 0 0 0
1 0003 00 0 0
// inverted LEMO trigger
1 0001 00 0 0
1 0002 02 0 0
4 1 1 0 0
9 6 0 0 0
1 0001 01 0 0
3 1 0 2 1
9 8 0 0 0
5 81001236 1 0 0
6 1 0 0 0
1 0001 00 0 0
1 0002 00 0 0
4 1 0 0 0
9 6 0 0 0
// RJ45 plugged in
4 0 0 0 0
4 2 0 0 0
9 6 0 0 0
8 0 0 0 0
1 0001 01 0 0
9 4 0 0 0
8 1 0 0 0
3 0 1 2 1
9 8 0 0 0
5 81001237 1 0 0
6 1 0 0 0
3 1 1 2 1
9 8 0 0 0
6 1 0 0 0
// overflow, two words lost
3 0 1 2 a
9 8 0 0 0
2 0004 02 0 0
5 81001238 8 0 0
6 1 0 0 0
// TLU reset input enabled, then disabled
1 0001 05 0 0
3 2 1 2 1
9 8 0 0 0
2 0008 00 0 0
2 0009 00 0 0
2 000a 00 0 0
2 000b 00 0 0
3 0 1 2 1
9 8 0 0 0
5 80000000 1 0 0
6 1 0 0 0
1 0001 01 0 0
3 2 1 2 1
9 8 0 0 0
2 0008 01 0 0
2 000b 00 0 0
3 0 1 2 1
9 8 0 0 0
5 80000001 1 0 0
6 1 0 0 0
0 0 0 0 0

// File: compile.f
tlu_pkg.sv
tlu_input_channel.sv
tlu_reg_bank.sv
tlu_port_select.sv
tlu_trigger_handler.sv
tlu_data_fifo.sv
tlu_controller_top.sv
tlu_checker.sv
tlu_monitor.sv
tb_tlu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator and run from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_tlu -o tb_tlu \
    && ./obj_dir/tb_tlu | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
